/* all.f */
verilog/trafgen_pkg.sv
verilog/mmio_axil_port.sv
verilog/cfg_regs.sv
verilog/run_control.sv
verilog/trace_buffer.sv
verilog/trafgen_mmio_top.sv
dv/tb_trafgen_mmio.sv

/* dv/tb_trafgen_mmio.sv */
// Self-checking testbench of the traffic generator MMIO block over AXI4-Lite and engine ports
`default_nettype none

module tb_trafgen_mmio;
   timeunit 1ns;
   timeprecision 1ps;
   import trafgen_pkg::*;

   localparam int N_EV = 6;  // Command events per trace
   localparam longint WD_CYCLES = 5 * (20 * TRACE_DEPTH + 200);

   logic clk = 1'b0;
   logic resetn;
   logic [31:0] awaddr, wdata, araddr, rdata;
   logic [3:0]  wstrb;
   logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready;
   logic rvalid, rready;
   logic [1:0] bresp, rresp, rd_error;
   logic tt_arvalid, tt_awvalid, rd_done_pulse, wr_done_pulse, wr_error, engine_start_pulse;
   logic [4:0]  tt_arid, tt_awid;
   logic        wrap_mode;
   logic [3:0]  wrap_len;
   logic [31:0] rd_pattern, rd_number, wr_pattern, wr_number;
   logic [63:0] source_address, target_address;

   // Shadow of the register file and flags
   logic [31:0] shadow [64];
   logic sh_start, sh_idle, sh_ready, sh_rd_done, sh_wr_done, sh_wr_err;
   logic [1:0]  sh_rd_err;
   logic [31:0] rw_addr [11];
   logic [31:0] rng_state = 32'h8e23;
   int          errors = 0;
   int          pulse_count = 0;
   logic [4:0]  ids_rd [N_EV];
   logic [4:0]  ids_wr [N_EV];
   int          gaps [N_EV];
   logic [31:0] stamp0_rd, stamp0_wr;

   trafgen_mmio_top i_dut (
      .clk, .resetn,
      .s_axi_awaddr(awaddr), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
      .s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wvalid(wvalid), .s_axi_wready(wready),
      .s_axi_bvalid(bvalid), .s_axi_bresp(bresp), .s_axi_bready(bready),
      .s_axi_araddr(araddr), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
      .s_axi_rvalid(rvalid), .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rready(rready),
      .tt_arvalid, .tt_awvalid, .tt_arid, .tt_awid, .rd_done_pulse, .wr_done_pulse,
      .rd_error, .wr_error, .engine_start_pulse, .wrap_mode, .wrap_len,
      .rd_pattern, .rd_number, .wr_pattern, .wr_number, .source_address, .target_address
   );

   always #10 clk = ~clk;  // 20 ns period

   // Start pulses counted where values are settled
   always @(negedge clk) begin
      if (engine_start_pulse)
         pulse_count <= pulse_count + 1;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Expected readback of a non-trace address
   function automatic logic [31:0] expected_read(input logic [31:0] addr);
      case (addr)
         A_CONTROL:     return {28'h0, sh_ready, sh_idle, 1'b0, sh_start};
         A_USER_STATUS: return {26'h0, sh_ready, sh_rd_err, sh_wr_err, sh_rd_done, sh_wr_done};
         A_USER_CONTROL, A_USER_MODE, A_RD_PATTERN, A_RD_NUMBER, A_WR_PATTERN,
         A_WR_NUMBER, A_SRC_L, A_SRC_H, A_TGT_L, A_TGT_H, A_SOFT_RESET:
            return shadow[addr[7:2]];
         default:       return DEFAULT_RDATA;
      endcase
   endfunction

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch %s got %h exp %h", name, got, exp);
      end
   endtask

   // ------------------------------------------------------------------------
   // AXI4-Lite host
   // ------------------------------------------------------------------------
   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      @(posedge clk);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      do @(negedge clk); while (!(awready && wready));
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(negedge clk); while (!bvalid);
      compare("bresp", 64'(bresp), 64'h0);
      @(posedge clk);  // Register update lands here
   endtask

   task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      do @(negedge clk); while (!rvalid);
      data = rdata;
      compare("rresp", 64'(rresp), 64'h0);
   endtask

   // Write plus shadow update following byte strobes
   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [31:0] m;
      axil_write(addr, data, strb);
      m = shadow[addr[7:2]];
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            m[b*8 +: 8] = data[b*8 +: 8];
      end
      if (addr == A_CONTROL) begin
         if (strb[0])
            sh_start = data[0];
      end else begin
         shadow[addr[7:2]] = m;
      end
      if (addr == A_USER_CONTROL && m[1])
         sh_idle = 1'b1;
      if (addr == A_SOFT_RESET && m[0])
         clear_shadow();
      @(posedge clk);  // Let flags settle
   endtask

   task automatic clear_shadow();
      for (int i = 0; i < 64; i++)
         shadow[i] = 32'h0;
      {sh_start, sh_idle, sh_ready, sh_rd_done, sh_wr_done, sh_wr_err} = 6'h0;
      sh_rd_err = 2'b00;
   endtask

   task automatic check_read(input logic [31:0] addr);
      logic [31:0] d;
      axil_read(addr, d);
      if (d !== expected_read(addr)) begin
         errors++;
         $display("mismatch rdata@%h got %h exp %h", addr, d, expected_read(addr));
      end
   endtask

   task automatic check_engine_outputs();
      compare("wrap_mode", 64'(wrap_mode), 64'(shadow[A_USER_MODE[7:2]][0]));
      compare("wrap_len", 64'(wrap_len), 64'(shadow[A_USER_MODE[7:2]][11:8]));
      compare("rd_pattern", 64'(rd_pattern), 64'(shadow[A_RD_PATTERN[7:2]]));
      compare("rd_number", 64'(rd_number), 64'(shadow[A_RD_NUMBER[7:2]]));
      compare("wr_pattern", 64'(wr_pattern), 64'(shadow[A_WR_PATTERN[7:2]]));
      compare("wr_number", 64'(wr_number), 64'(shadow[A_WR_NUMBER[7:2]]));
      compare("source_address", source_address,
              {shadow[A_SRC_H[7:2]], shadow[A_SRC_L[7:2]]});
      compare("target_address", target_address,
              {shadow[A_TGT_H[7:2]], shadow[A_TGT_L[7:2]]});
   endtask

   task automatic check_all_regs();
      for (int i = 0; i < 11; i++)
         check_read(rw_addr[i]);
      check_read(A_USER_STATUS);
      check_engine_outputs();
   endtask

   // Watchdog sized from the test steps
   initial begin
      #(WD_CYCLES * 20);
      $display("watchdog timeout, the run did not finish in time");
      $display("Regression failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial begin
      logic [31:0] d, prev;
      logic        got_ready;
      int          extra;
      rw_addr = '{A_CONTROL, A_USER_CONTROL, A_USER_MODE, A_RD_PATTERN, A_RD_NUMBER,
                  A_WR_PATTERN, A_WR_NUMBER, A_SRC_L, A_SRC_H, A_TGT_L, A_TGT_H};
      clear_shadow();
      resetn <= 1'b0;
      {awvalid, wvalid, arvalid} <= 3'b000;
      {bready, rready} <= 2'b11;
      awaddr <= '0;
      wdata  <= '0;
      wstrb  <= '0;
      araddr <= '0;
      {tt_arvalid, tt_awvalid, rd_done_pulse, wr_done_pulse, wr_error} <= 5'b0;
      tt_arid  <= '0;
      tt_awid  <= '0;
      rd_error <= 2'b00;
      repeat (4) @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      // Only arready is up out of reset
      compare("awready,wready,bvalid,rvalid,arready",
              64'({awready, wready, bvalid, rvalid, arready}), 64'h1);

      // Step 1: random writes, engine bits kept low
      for (int r = 0; r < 3; r++) begin
         for (int i = 0; i < 11; i++) begin
            d = next_rand();
            if (rw_addr[i] == A_CONTROL || rw_addr[i] == A_USER_CONTROL)
               d = d & ~32'h3;
            reg_write(rw_addr[i], d, 4'(next_rand()));
         end
         check_all_regs();
      end
      check_read(32'h10);  // Unmapped
      check_read(32'h90);

      // Step 2: clear phase
      reg_write(A_RD_NUMBER, 32'h0, 4'hf);
      reg_write(A_WR_NUMBER, 32'h5, 4'hf);
      reg_write(A_CONTROL, 32'h1, 4'hf);
      got_ready = 1'b0;
      for (int p = 0; p < 2 * TRACE_DEPTH && !got_ready; p++) begin
         axil_read(A_USER_STATUS, d);
         got_ready = d[5];
      end
      if (!got_ready) begin
         errors++;
         $display("engine ready never set after the clear phase");
      end
      sh_ready = 1'b1;
      check_read(A_CONTROL);
      for (int k = 0; k < TRACE_DEPTH; k++) begin
         axil_read(A_TT_ARID, d);
         compare("tt_arid", 64'(d), 64'h0);
         axil_read(A_TT_RD_CMD, d);
         compare("tt_rd_cmd", 64'(d), 64'h0);
         axil_read(A_TT_AWID, d);
         compare("tt_awid", 64'(d), 64'h0);
         axil_read(A_TT_WR_CMD, d);
         compare("tt_wr_cmd", 64'(d), 64'h0);
      end

      // Step 3: engine start, read side finishes at once
      reg_write(A_USER_CONTROL, 32'h1, 4'hf);
      sh_rd_done = 1'b1;
      repeat (3) @(posedge clk);
      compare("engine_start_pulse count", 64'(pulse_count), 64'h1);
      check_read(A_USER_STATUS);

      // Step 4: command events with random gaps
      for (int e = 0; e < N_EV; e++) begin
         ids_rd[e] = 5'(next_rand());
         ids_wr[e] = 5'(next_rand());
         extra     = int'(next_rand() % 6);
         gaps[e]   = extra + 2;  // Set edge, clear edge, idle edges
         @(posedge clk);
         tt_arvalid <= 1'b1;
         tt_awvalid <= 1'b1;
         tt_arid    <= ids_rd[e];
         tt_awid    <= ids_wr[e];
         @(posedge clk);
         tt_arvalid <= 1'b0;
         tt_awvalid <= 1'b0;
         repeat (extra) @(posedge clk);
      end
      @(posedge clk);
      rd_done_pulse <= 1'b1;  // Rewinds both traces
      wr_done_pulse <= 1'b1;
      @(posedge clk);
      rd_done_pulse <= 1'b0;
      wr_done_pulse <= 1'b0;
      sh_wr_done = 1'b1;
      check_read(A_USER_STATUS);
      prev = '0;
      // Gap after event e-1 separates it from event e
      for (int e = 0; e < N_EV; e++) begin
         axil_read(A_TT_ARID, d);
         compare("tt_arid", 64'(d), 64'(ids_rd[e]));
         axil_read(A_TT_RD_CMD, d);
         if (e == 0)
            stamp0_rd = d;
         else
            compare("tt_rd_cmd gap", 64'(d - prev), 64'(gaps[e-1]));
         prev = d;
      end
      for (int e = 0; e < N_EV; e++) begin
         axil_read(A_TT_AWID, d);
         compare("tt_awid", 64'(d), 64'(ids_wr[e]));
         axil_read(A_TT_WR_CMD, d);
         if (e == 0)
            stamp0_wr = d;
         else
            compare("tt_wr_cmd gap", 64'(d - prev), 64'(gaps[e-1]));
         prev = d;
      end

      // Step 5: sticky errors, rewind, finish dump, soft reset
      @(posedge clk);
      rd_error <= 2'b10;
      wr_error <= 1'b1;
      @(posedge clk);
      rd_error <= 2'b00;
      wr_error <= 1'b0;
      sh_rd_err = 2'b10;
      sh_wr_err = 1'b1;
      check_read(A_USER_STATUS);
      axil_read(A_TT_ARID, d);
      compare("tt_arid rewound", 64'(d), 64'(ids_rd[0]));
      axil_read(A_TT_RD_CMD, d);
      compare("tt_rd_cmd rewound", 64'(d), 64'(stamp0_rd));
      axil_read(A_TT_AWID, d);
      compare("tt_awid rewound", 64'(d), 64'(ids_wr[0]));
      axil_read(A_TT_WR_CMD, d);
      compare("tt_wr_cmd rewound", 64'(d), 64'(stamp0_wr));
      reg_write(A_USER_CONTROL, 32'h3, 4'hf);
      check_read(A_CONTROL);
      reg_write(A_SOFT_RESET, 32'h1, 4'hf);
      check_all_regs();
      check_read(A_SOFT_RESET);

      $display("errors %0d", errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f all.f --top-module tb_trafgen_mmio -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Regression passed" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

/* verilog/cfg_regs.sv */
// Configuration registers with byte strobes and soft reset, plus the MMIO read multiplexer
`default_nettype none

module cfg_regs (
   input  logic                               clk,
   input  logic                               resetn,
   // From the MMIO port
   input  logic                               reg_wr_en,
   input  logic [trafgen_pkg::AXIL_ADDR_W-1:0] reg_wr_addr,
   input  logic [trafgen_pkg::AXIL_DATA_W-1:0] reg_wr_data,
   input  logic [trafgen_pkg::AXIL_STRB_W-1:0] reg_wr_strb,
   input  logic                               reg_rd_en,
   input  logic [trafgen_pkg::AXIL_ADDR_W-1:0] reg_rd_addr,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] reg_rd_data,
   // Status from run control and the traces
   input  logic [trafgen_pkg::AXIL_DATA_W-1:0] status_word,
   input  logic                               ready,
   input  logic                               idle,
   input  trafgen_pkg::trace_entry_t          rd_entry,
   input  trafgen_pkg::trace_entry_t          wr_entry,
   // Control outputs
   output logic                               start_bit,
   output logic                               engine_bit,
   output logic                               finish_dump,
   output logic                               soft_reset,
   output logic                               rd_pop,
   output logic                               wr_pop,
   // Engine configuration
   output logic                               wrap_mode,
   output logic [trafgen_pkg::WRAP_LEN_W-1:0]  wrap_len,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] rd_pattern,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] rd_number,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] wr_pattern,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] wr_number,
   output logic [trafgen_pkg::HOST_ADDR_W-1:0] source_address,
   output logic [trafgen_pkg::HOST_ADDR_W-1:0] target_address
);
   import trafgen_pkg::*;

   logic                   start_q;       // CONTROL start, the only stored bit
   logic [AXIL_DATA_W-1:0] user_ctrl_q;
   logic [AXIL_DATA_W-1:0] user_mode_q;
   logic [AXIL_DATA_W-1:0] soft_reset_q;
   logic [AXIL_DATA_W-1:0] ctrl_rd;

   // Byte-strobe merge of the write data into a current word
   function automatic logic [AXIL_DATA_W-1:0] merge(input logic [AXIL_DATA_W-1:0] cur);
      logic [AXIL_DATA_W-1:0] res;
      res = cur;
      for (int b = 0; b < AXIL_STRB_W; b++) begin
         if (reg_wr_strb[b])
            res[b*8 +: 8] = reg_wr_data[b*8 +: 8];
      end
      return res;
   endfunction

   // ------------------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!resetn || soft_reset) begin  // Soft reset also clears itself
         start_q        <= 1'b0;
         user_ctrl_q    <= '0;
         user_mode_q    <= '0;
         rd_pattern     <= '0;
         rd_number      <= '0;
         wr_pattern     <= '0;
         wr_number      <= '0;
         source_address <= '0;
         target_address <= '0;
         soft_reset_q   <= '0;
      end else if (reg_wr_en) begin
         case (reg_wr_addr)
            A_CONTROL:      start_q <= reg_wr_strb[0] ? reg_wr_data[CTRL_START_BIT] : start_q;
            A_USER_CONTROL: user_ctrl_q  <= merge(user_ctrl_q);
            A_USER_MODE:    user_mode_q  <= merge(user_mode_q);
            A_RD_PATTERN:   rd_pattern   <= merge(rd_pattern);
            A_RD_NUMBER:    rd_number    <= merge(rd_number);
            A_WR_PATTERN:   wr_pattern   <= merge(wr_pattern);
            A_WR_NUMBER:    wr_number    <= merge(wr_number);
            A_SRC_L:        source_address[31:0]  <= merge(source_address[31:0]);
            A_SRC_H:        source_address[63:32] <= merge(source_address[63:32]);
            A_TGT_L:        target_address[31:0]  <= merge(target_address[31:0]);
            A_TGT_H:        target_address[63:32] <= merge(target_address[63:32]);
            A_SOFT_RESET:   soft_reset_q <= merge(soft_reset_q);
            default: ;  // RO or unmapped
         endcase
      end
   end

   assign start_bit   = start_q;
   assign engine_bit  = user_ctrl_q[UCTRL_ENGINE_START_BIT];
   assign finish_dump = user_ctrl_q[UCTRL_FINISH_DUMP_BIT];
   assign soft_reset  = soft_reset_q[0];
   assign wrap_mode   = user_mode_q[MODE_WRAP_BIT];
   assign wrap_len    = user_mode_q[MODE_LEN_LSB +: WRAP_LEN_W];

   // Trace data reads pop, ID reads only peek
   assign rd_pop = reg_rd_en && (reg_rd_addr == A_TT_RD_CMD);
   assign wr_pop = reg_rd_en && (reg_rd_addr == A_TT_WR_CMD);

   // ------------------------------------------------------------------------
   // Read multiplexer
   // ------------------------------------------------------------------------
   always_comb begin
      ctrl_rd                 = '0;
      ctrl_rd[CTRL_START_BIT] = start_q;
      ctrl_rd[CTRL_IDLE_BIT]  = idle;
      ctrl_rd[CTRL_READY_BIT] = ready;
   end

   always_comb begin
      case (reg_rd_addr)
         A_CONTROL:      reg_rd_data = ctrl_rd;
         A_USER_STATUS:  reg_rd_data = status_word;
         A_USER_CONTROL: reg_rd_data = user_ctrl_q;
         A_USER_MODE:    reg_rd_data = user_mode_q;
         A_TT_RD_CMD:    reg_rd_data = rd_entry.cycle;
         A_TT_WR_CMD:    reg_rd_data = wr_entry.cycle;
         A_TT_ARID:      reg_rd_data = {{(AXIL_DATA_W-ID_W){1'b0}}, rd_entry.id};
         A_TT_AWID:      reg_rd_data = {{(AXIL_DATA_W-ID_W){1'b0}}, wr_entry.id};
         A_RD_PATTERN:   reg_rd_data = rd_pattern;
         A_RD_NUMBER:    reg_rd_data = rd_number;
         A_WR_PATTERN:   reg_rd_data = wr_pattern;
         A_WR_NUMBER:    reg_rd_data = wr_number;
         A_SRC_L:        reg_rd_data = source_address[31:0];
         A_SRC_H:        reg_rd_data = source_address[63:32];
         A_TGT_L:        reg_rd_data = target_address[31:0];
         A_TGT_H:        reg_rd_data = target_address[63:32];
         A_SOFT_RESET:   reg_rd_data = soft_reset_q;
         default:        reg_rd_data = DEFAULT_RDATA;
      endcase
   end

endmodule

`default_nettype wire

/* verilog/mmio_axil_port.sv */
// AXI4-Lite slave handshakes, turned into one-cycle register write and read strobes
`default_nettype none

module mmio_axil_port (
   input  logic                               clk,
   input  logic                               resetn,
   // AXI4-Lite write address and data
   input  logic [trafgen_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
   input  logic                               s_axi_awvalid,
   output logic                               s_axi_awready,
   input  logic [trafgen_pkg::AXIL_DATA_W-1:0] s_axi_wdata,
   input  logic [trafgen_pkg::AXIL_STRB_W-1:0] s_axi_wstrb,
   input  logic                               s_axi_wvalid,
   output logic                               s_axi_wready,
   // Write response
   output logic                               s_axi_bvalid,
   output logic [1:0]                         s_axi_bresp,
   input  logic                               s_axi_bready,
   // Read address and data
   input  logic [trafgen_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
   input  logic                               s_axi_arvalid,
   output logic                               s_axi_arready,
   output logic                               s_axi_rvalid,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] s_axi_rdata,
   output logic [1:0]                         s_axi_rresp,
   input  logic                               s_axi_rready,
   // Register side
   output logic                               reg_wr_en,
   output logic [trafgen_pkg::AXIL_ADDR_W-1:0] reg_wr_addr,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] reg_wr_data,
   output logic [trafgen_pkg::AXIL_STRB_W-1:0] reg_wr_strb,
   output logic                               reg_rd_en,
   output logic [trafgen_pkg::AXIL_ADDR_W-1:0] reg_rd_addr,
   input  logic [trafgen_pkg::AXIL_DATA_W-1:0] reg_rd_data
);
   import trafgen_pkg::*;

   logic wr_rdy_q;  // Shared awready/wready
   logic wr_hs;
   logic rd_hs;

   assign s_axi_awready = wr_rdy_q;
   assign s_axi_wready  = wr_rdy_q;
   assign s_axi_arready = ~s_axi_rvalid;  // Held rvalid blocks the next read
   assign s_axi_bresp   = 2'b00;          // OKAY
   assign s_axi_rresp   = 2'b00;

   assign wr_hs = wr_rdy_q & s_axi_awvalid & s_axi_wvalid;
   assign rd_hs = s_axi_arvalid & s_axi_arready;

   // Read strobe goes out in the handshake cycle itself
   assign reg_rd_en   = rd_hs;
   assign reg_rd_addr = s_axi_araddr;

   // ------------------------------------------------------------------------
   // Control state
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_rdy_q     <= 1'b0;
         s_axi_bvalid <= 1'b0;
         s_axi_rvalid <= 1'b0;
         reg_wr_en    <= 1'b0;
      end else begin
         // One-cycle ready pulse, never while a response is pending
         wr_rdy_q  <= s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid & ~wr_rdy_q;
         reg_wr_en <= wr_hs;
         if (wr_hs)
            s_axi_bvalid <= 1'b1;
         else if (s_axi_bready)
            s_axi_bvalid <= 1'b0;
         if (rd_hs)
            s_axi_rvalid <= 1'b1;
         else if (s_axi_rready)
            s_axi_rvalid <= 1'b0;
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      if (wr_hs) begin
         reg_wr_addr <= s_axi_awaddr;
         reg_wr_data <= s_axi_wdata;
         reg_wr_strb <= s_axi_wstrb;
      end
      if (rd_hs)
         s_axi_rdata <= reg_rd_data;  // Sampled before any trace pop lands
   end

endmodule

`default_nettype wire

/* verilog/run_control.sv */
// Start sequencing, trace clear countdown, sticky status flags and the cycle counter
`default_nettype none

module run_control (
   input  logic                               clk,
   input  logic                               resetn,
   input  logic                               start_bit,
   input  logic                               engine_bit,
   input  logic                               finish_dump,
   input  logic                               soft_reset,
   input  logic [trafgen_pkg::AXIL_DATA_W-1:0] rd_number,
   input  logic [trafgen_pkg::AXIL_DATA_W-1:0] wr_number,
   // Engine status
   input  logic                               rd_done_pulse,
   input  logic                               wr_done_pulse,
   input  logic [1:0]                         rd_error,  // Bit 0 response, bit 1 data
   input  logic                               wr_error,
   // Outputs
   output logic                               engine_start_pulse,
   output logic                               clear,
   output logic [trafgen_pkg::CYCLE_W-1:0]     cycle,
   output logic                               rd_rewind,
   output logic                               wr_rewind,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] status_word,
   output logic                               ready,
   output logic                               idle
);
   import trafgen_pkg::*;

   logic                   engine_q;     // Previous engine_bit
   logic                   engine_ready_q;
   logic [TRACE_PTR_W-1:0] clr_cnt_q;    // Clear countdown
   logic                   rd_done_q;
   logic                   wr_done_q;
   logic [1:0]             rd_error_q;
   logic                   wr_error_q;
   logic                   idle_q;

   assign engine_start_pulse = engine_bit & ~engine_q;  // First cycle seen high
   assign clear              = start_bit & ~engine_ready_q;
   assign rd_rewind          = rd_done_pulse | (|rd_error);
   assign wr_rewind          = wr_done_pulse | wr_error;

   // ------------------------------------------------------------------------
   // Flags and countdown
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!resetn || soft_reset) begin
         engine_q       <= 1'b0;
         engine_ready_q <= 1'b0;
         clr_cnt_q      <= TRACE_PTR_W'(TRACE_DEPTH - 1);
         rd_done_q      <= 1'b0;
         wr_done_q      <= 1'b0;
         rd_error_q     <= 2'b00;
         wr_error_q     <= 1'b0;
         idle_q         <= 1'b0;
      end else begin
         engine_q <= engine_bit;
         // One trace word cleared per cycle, then ready
         if (start_bit) begin
            if (clr_cnt_q != '0)
               clr_cnt_q <= clr_cnt_q - 1'b1;
            else
               engine_ready_q <= 1'b1;
         end
         // Done also sets at start when nothing to issue
         if (rd_done_pulse || (engine_start_pulse && rd_number == '0))
            rd_done_q <= 1'b1;
         if (wr_done_pulse || (engine_start_pulse && wr_number == '0))
            wr_done_q <= 1'b1;
         if (|rd_error)
            rd_error_q <= rd_error;  // Keeps the latest nonzero code
         if (wr_error)
            wr_error_q <= 1'b1;
         if (finish_dump)
            idle_q <= 1'b1;
      end
   end

   // Cycle counter, runs from engine start until both directions finish
   always_ff @(posedge clk) begin
      if (!resetn || soft_reset)
         cycle <= '0;
      else if (engine_bit && !(rd_done_q && wr_done_q))
         cycle <= cycle + 1'b1;
   end

   assign status_word = {{(AXIL_DATA_W-6){1'b0}}, engine_ready_q, rd_error_q,
                         wr_error_q, rd_done_q, wr_done_q};
   assign ready = engine_ready_q;
   assign idle  = idle_q;

endmodule

`default_nettype wire

/* verilog/trace_buffer.sv */
// Time trace memory with one wrap-around pointer for write, pop and rewind
`default_nettype none

module trace_buffer (
   input  logic                           clk,
   input  logic                           resetn,
   input  logic                           soft_reset,
   input  logic                           clear,        // Zero-fill phase
   input  logic                           event_valid,  // Engine command issued
   input  logic [trafgen_pkg::ID_W-1:0]    event_id,
   input  logic [trafgen_pkg::CYCLE_W-1:0] cycle,
   input  logic                           pop,          // MMIO read of the data word
   input  logic                           rewind,
   output trafgen_pkg::trace_entry_t      entry
);
   import trafgen_pkg::*;

   trace_entry_t           mem [TRACE_DEPTH];
   logic [TRACE_PTR_W-1:0] ptr_q;
   logic                   wr_en;

   assign wr_en = event_valid | clear;

   // Pointer wraps naturally at TRACE_DEPTH
   always_ff @(posedge clk) begin
      if (!resetn || soft_reset || rewind)
         ptr_q <= '0;
      else if (wr_en || pop)
         ptr_q <= ptr_q + 1'b1;
   end

   // Storage, older entries are overwritten on wrap
   always_ff @(posedge clk) begin
      if (wr_en) begin
         if (clear)
            mem[ptr_q] <= '0;
         else
            mem[ptr_q] <= '{id: event_id, cycle: cycle};
      end
   end

   assign entry = mem[ptr_q];

endmodule

`default_nettype wire

/* verilog/trafgen_mmio_top.sv */
// Traffic generator MMIO top, wiring host port, registers, run control and two traces
`default_nettype none

module trafgen_mmio_top (
   input  logic                               clk,
   input  logic                               resetn,
   // AXI4-Lite host port
   input  logic [trafgen_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
   input  logic                               s_axi_awvalid,
   output logic                               s_axi_awready,
   input  logic [trafgen_pkg::AXIL_DATA_W-1:0] s_axi_wdata,
   input  logic [trafgen_pkg::AXIL_STRB_W-1:0] s_axi_wstrb,
   input  logic                               s_axi_wvalid,
   output logic                               s_axi_wready,
   output logic                               s_axi_bvalid,
   output logic [1:0]                         s_axi_bresp,
   input  logic                               s_axi_bready,
   input  logic [trafgen_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
   input  logic                               s_axi_arvalid,
   output logic                               s_axi_arready,
   output logic                               s_axi_rvalid,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] s_axi_rdata,
   output logic [1:0]                         s_axi_rresp,
   input  logic                               s_axi_rready,
   // Engine side
   input  logic                               tt_arvalid,
   input  logic                               tt_awvalid,
   input  logic [trafgen_pkg::ID_W-1:0]        tt_arid,
   input  logic [trafgen_pkg::ID_W-1:0]        tt_awid,
   input  logic                               rd_done_pulse,
   input  logic                               wr_done_pulse,
   input  logic [1:0]                         rd_error,
   input  logic                               wr_error,
   output logic                               engine_start_pulse,
   output logic                               wrap_mode,
   output logic [trafgen_pkg::WRAP_LEN_W-1:0]  wrap_len,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] rd_pattern,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] rd_number,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] wr_pattern,
   output logic [trafgen_pkg::AXIL_DATA_W-1:0] wr_number,
   output logic [trafgen_pkg::HOST_ADDR_W-1:0] source_address,
   output logic [trafgen_pkg::HOST_ADDR_W-1:0] target_address
);
   import trafgen_pkg::*;

   // Port to registers
   logic                   reg_wr_en;
   logic [AXIL_ADDR_W-1:0] reg_wr_addr;
   logic [AXIL_DATA_W-1:0] reg_wr_data;
   logic [AXIL_STRB_W-1:0] reg_wr_strb;
   logic                   reg_rd_en;
   logic [AXIL_ADDR_W-1:0] reg_rd_addr;
   logic [AXIL_DATA_W-1:0] reg_rd_data;
   // Registers, control and traces
   logic                   start_bit, engine_bit, finish_dump, soft_reset;
   logic                   rd_pop, wr_pop, clear, rd_rewind, wr_rewind, ready, idle;
   logic [CYCLE_W-1:0]     cycle;
   logic [AXIL_DATA_W-1:0] status_word;
   trace_entry_t           rd_entry, wr_entry;

   mmio_axil_port u_port (.*);

   cfg_regs u_regs (.*);

   run_control u_ctrl (.*);

   // Read command trace
   trace_buffer u_trace_rd (
      .clk, .resetn, .soft_reset, .clear, .cycle,
      .event_valid(tt_arvalid), .event_id(tt_arid),
      .pop(rd_pop), .rewind(rd_rewind), .entry(rd_entry)
   );

   // Write command trace
   trace_buffer u_trace_wr (
      .clk, .resetn, .soft_reset, .clear, .cycle,
      .event_valid(tt_awvalid), .event_id(tt_awid),
      .pop(wr_pop), .rewind(wr_rewind), .entry(wr_entry)
   );

endmodule

`default_nettype wire

/* verilog/trafgen_pkg.sv */
// Shared register map, field widths and trace entry type of the traffic generator MMIO block
`default_nettype none

package trafgen_pkg;

   // ------------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------------
   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
   localparam int ID_W        = 5;    // Engine transaction ID
   localparam int CYCLE_W     = 32;   // Cycle stamp
   localparam int HOST_ADDR_W = 64;
   localparam int WRAP_LEN_W  = 4;
   localparam int TRACE_DEPTH = 256;  // Entries per trace memory
   localparam int TRACE_PTR_W = $clog2(TRACE_DEPTH);

   typedef struct packed {
      logic [ID_W-1:0]    id;
      logic [CYCLE_W-1:0] cycle;
   } trace_entry_t;

   // ------------------------------------------------------------------------
   // Register addresses, one word each
   // ------------------------------------------------------------------------
   localparam logic [AXIL_ADDR_W-1:0] A_CONTROL      = 32'h00;
   localparam logic [AXIL_ADDR_W-1:0] A_USER_STATUS  = 32'h30;  // RO
   localparam logic [AXIL_ADDR_W-1:0] A_USER_CONTROL = 32'h34;
   localparam logic [AXIL_ADDR_W-1:0] A_USER_MODE    = 32'h38;
   localparam logic [AXIL_ADDR_W-1:0] A_TT_RD_CMD    = 32'h44;  // Pops read trace
   localparam logic [AXIL_ADDR_W-1:0] A_TT_WR_CMD    = 32'h4C;  // Pops write trace
   localparam logic [AXIL_ADDR_W-1:0] A_TT_ARID      = 32'h54;
   localparam logic [AXIL_ADDR_W-1:0] A_TT_AWID      = 32'h58;
   localparam logic [AXIL_ADDR_W-1:0] A_RD_PATTERN   = 32'h64;
   localparam logic [AXIL_ADDR_W-1:0] A_RD_NUMBER    = 32'h68;
   localparam logic [AXIL_ADDR_W-1:0] A_WR_PATTERN   = 32'h6C;
   localparam logic [AXIL_ADDR_W-1:0] A_WR_NUMBER    = 32'h70;
   localparam logic [AXIL_ADDR_W-1:0] A_SRC_L        = 32'h74;
   localparam logic [AXIL_ADDR_W-1:0] A_SRC_H        = 32'h78;
   localparam logic [AXIL_ADDR_W-1:0] A_TGT_L        = 32'h7C;
   localparam logic [AXIL_ADDR_W-1:0] A_TGT_H        = 32'h80;
   localparam logic [AXIL_ADDR_W-1:0] A_SOFT_RESET   = 32'h8C;

   localparam logic [AXIL_DATA_W-1:0] DEFAULT_RDATA = 32'h5a5aa5a5;  // Unmapped reads

   // Bit positions
   localparam int CTRL_START_BIT         = 0;
   localparam int CTRL_IDLE_BIT          = 2;
   localparam int CTRL_READY_BIT         = 3;
   localparam int UCTRL_ENGINE_START_BIT = 0;
   localparam int UCTRL_FINISH_DUMP_BIT  = 1;
   localparam int MODE_WRAP_BIT          = 0;
   localparam int MODE_LEN_LSB           = 8;

endpackage

`default_nettype wire
